// ==== gaplus_pkg.sv ====
/*
  shared constants for the main-CPU bus glue.
  region selects are compared against the top address bits only,
  so every region is mirrored across its whole decode window.
  the I/O chip mode lives in one nibble register of each chip.
*/

package gaplus_pkg;

	// ----------------------------------------------------------------------
	// address map, upper bits of cpu_addr
	// ----------------------------------------------------------------------
	localparam logic [0:0] irom_sel = 1'b1;      // 8000-ffff, [15].
	localparam logic [2:0] mram_sel = 3'b000;    // 0000-1fff, [15:13].
	localparam logic [4:0] sndw_sel = 5'b01100;  // 6000-67ff, [15:11].
	localparam logic [4:0] io_sel   = 5'b01101;  // 6800-6fff, [15:11].
	localparam logic [3:0] srst_sel = 4'b1000;   // 8000-8fff write, [15:12].
	localparam logic [3:0] irqe_sel = 4'b0111;   // 7000-7fff write, [15:12].
	localparam logic [4:0] star_sel = 5'b10100;  // a000-a7ff write, [15:11].

	// byte seen on reads that hit nothing.
	localparam logic [7:0] unmapped_data = 8'hFF;

	// ----------------------------------------------------------------------
	// custom I/O chips
	// ----------------------------------------------------------------------
	localparam int io_chip_count    = 3;
	localparam int io_regs_per_chip = 16;

	localparam logic [3:0] io_mode_offset = 4'd8;  // mode nibble per chip.
	localparam logic [3:0] io_kick_offset = 4'd9;  // chip 2 only.

	// chip operating modes, as written to the mode register.
	typedef enum logic [3:0] {
		io_mode_idle   = 4'h0,  // registers hold CPU data.
		io_mode_switch = 4'h1,  // vblank edge loads inputs.
		io_mode_test   = 4'h8   // regs 0-7 read inverted.
	} io_mode_t;

endpackage

// ==== gaplus_io.sv ====
/*
  bank of three custom I/O chips, 16 nibble registers each.
  address bits 5:4 pick the chip, 3:0 the register; chip 3 is absent.
  in switch mode a vblank rising edge copies the player inputs in.
  a CPU write in the same cycle wins over the capture.
  kick_explode is a one-cycle pulse after a nonzero kick write.
*/

`timescale 1ns/1ps

module gaplus_io (
	input  logic        MCPU_CLK,
	input  logic        RESET,
	input  logic        vblk,

	input  logic [15:0] cpu_addr,
	input  logic        cpu_rw,
	input  logic [7:0]  cpu_do,
	input  logic        io_cs,

	input  logic [31:0] inp0,
	input  logic [31:0] inp1,
	input  logic [3:0]  inp2,

	output logic [7:0]  io_rd,
	output logic        kick_explode
);

	localparam int nchip = gaplus_pkg::io_chip_count;
	localparam int nreg  = gaplus_pkg::io_regs_per_chip;

	logic [3:0] regs [nchip][nreg];

	gaplus_pkg::io_mode_t chip_mode [nchip];

	logic [1:0] sel_chip;
	logic [3:0] sel_reg;
	logic       chip_ok;
	logic       io_wr;
	logic       kick_wr;
	logic       vblk_d;
	logic       vblk_rise;

	// capture data and per-register load enables, regs 0-7 only.
	logic [3:0] cap_nib [nchip][8];
	logic [7:0] cap_en  [nchip];

	logic [3:0] rd_nib;

	// ----------------------------------------------------------------------
	// bus side
	// ----------------------------------------------------------------------
	assign sel_chip = cpu_addr[5:4];
	assign sel_reg  = cpu_addr[3:0];
	assign chip_ok  = (sel_chip != 2'd3);
	assign io_wr    = io_cs & ~cpu_rw & chip_ok;

	assign kick_wr = io_wr & (sel_chip == 2'd2) &
		(sel_reg == gaplus_pkg::io_kick_offset) & (cpu_do[3:0] != 4'h0);

	always_comb begin
		for (int c = 0; c < nchip; c++)
			chip_mode[c] = gaplus_pkg::io_mode_t'(regs[c][gaplus_pkg::io_mode_offset]);
	end

	// ----------------------------------------------------------------------
	// vblank capture
	// ----------------------------------------------------------------------
	assign vblk_rise = vblk & ~vblk_d;

	always_comb begin
		for (int r = 0; r < 8; r++) begin
			cap_nib[0][r] = inp0[r*4 +: 4];  // lowest nibble to reg 0.
			cap_nib[1][r] = inp1[r*4 +: 4];
			cap_nib[2][r] = 4'h0;
		end
		cap_nib[2][0] = inp2;

		for (int c = 0; c < nchip; c++) begin
			if (vblk_rise && chip_mode[c] == gaplus_pkg::io_mode_switch)
				cap_en[c] = (c == 2) ? 8'h01 : 8'hFF;  // chip 2 has one nibble.
			else
				cap_en[c] = 8'h00;
		end
	end

	always_ff @(posedge MCPU_CLK) begin
		if (RESET)
			vblk_d <= 1'b0;
		else
			vblk_d <= vblk;
	end

	// ----------------------------------------------------------------------
	// register file
	// ----------------------------------------------------------------------
	always_ff @(posedge MCPU_CLK) begin
		if (RESET) begin
			for (int c = 0; c < nchip; c++) begin
				for (int r = 0; r < nreg; r++)
					regs[c][r] <= 4'h0;
				regs[c][gaplus_pkg::io_mode_offset] <= gaplus_pkg::io_mode_idle;
			end
		end else begin
			for (int c = 0; c < nchip; c++) begin
				for (int r = 0; r < 8; r++) begin
					if (cap_en[c][r])
						regs[c][r] <= cap_nib[c][r];
				end
			end
			// last assignment, so the CPU wins a same-cycle collision.
			if (io_wr)
				regs[sel_chip][sel_reg] <= cpu_do[3:0];
		end
	end

	// ----------------------------------------------------------------------
	// read path
	// ----------------------------------------------------------------------
	always_comb begin
		rd_nib = 4'h0;
		if (chip_ok) begin
			rd_nib = regs[sel_chip][sel_reg];
			if (chip_mode[sel_chip] == gaplus_pkg::io_mode_test && !sel_reg[3])
				rd_nib = ~rd_nib;  // test pattern.
		end
	end

	assign io_rd = {4'h0, rd_nib};

	// explosion sound trigger.
	always_ff @(posedge MCPU_CLK) begin
		if (RESET)
			kick_explode <= 1'b0;
		else
			kick_explode <= kick_wr;
	end

endmodule

// ==== gaplus_main_decode.sv ====
/*
  main-CPU address decode and read-data selector.
  chip selects and cpu_di are combinational from the bus.
  sub-CPU reset and irq enable latch address bit 11 on the
  rising edge of a write cycle, with synchronous RESET.
  RAM and sound reads are qualified by cpu_vma only.
*/

`timescale 1ns/1ps

module gaplus_main_decode (
	input  logic        MCPU_CLK,
	input  logic        RESET,
	input  logic        vblk,

	input  logic [15:0] cpu_addr,
	input  logic        cpu_vma,
	input  logic        cpu_rw,

	input  logic [7:0]  rom_data,
	input  logic [7:0]  ram_rd,
	input  logic [7:0]  snd_rd,
	input  logic [7:0]  io_rd,

	output logic        rom_cs,
	output logic [14:0] rom_addr,
	output logic        ram_we,
	output logic        snd_we,
	output logic        star_cs,
	output logic        io_cs,
	output logic        sub_reset,
	output logic        cpu_irq,
	output logic [7:0]  cpu_di
);

	logic cpu_wr;
	logic mram_hit;
	logic sndw_hit;
	logic srst_wr;
	logic irqe_wr;
	logic irq_en;

	assign cpu_wr = cpu_vma & ~cpu_rw;

	// ----------------------------------------------------------------------
	// region decode
	// ----------------------------------------------------------------------
	assign rom_cs   = (cpu_addr[15] == gaplus_pkg::irom_sel[0]) & cpu_vma;
	assign mram_hit = (cpu_addr[15:13] == gaplus_pkg::mram_sel) & cpu_vma;
	assign sndw_hit = (cpu_addr[15:11] == gaplus_pkg::sndw_sel) & cpu_vma;
	assign io_cs    = (cpu_addr[15:11] == gaplus_pkg::io_sel) & cpu_vma;

	// write-only strobes.
	assign srst_wr = (cpu_addr[15:12] == gaplus_pkg::srst_sel) & cpu_wr;
	assign irqe_wr = (cpu_addr[15:12] == gaplus_pkg::irqe_sel) & cpu_wr;
	assign star_cs = (cpu_addr[15:11] == gaplus_pkg::star_sel) & cpu_wr;

	assign rom_addr = cpu_addr[14:0];
	assign ram_we   = mram_hit & ~cpu_rw;
	assign snd_we   = sndw_hit & ~cpu_rw;

	// ----------------------------------------------------------------------
	// control latches
	// ----------------------------------------------------------------------
	// a11 = 0 releases the sub CPU / enables the vblank irq,
	// a11 = 1 holds it in reset / masks the irq.
	always_ff @(posedge MCPU_CLK) begin
		if (RESET) begin
			sub_reset <= 1'b1;
			irq_en    <= 1'b1;  // active low enable, masked.
		end else begin
			if (srst_wr)
				sub_reset <= cpu_addr[11];
			if (irqe_wr)
				irq_en <= cpu_addr[11];
		end
	end

	assign cpu_irq = vblk & ~irq_en;

	// ----------------------------------------------------------------------
	// read-data selector
	// ----------------------------------------------------------------------
	always_comb begin
		if (rom_cs)
			cpu_di = rom_data;
		else if (mram_hit)
			cpu_di = ram_rd;
		else if (sndw_hit)
			cpu_di = snd_rd;
		else if (io_cs)
			cpu_di = io_rd;
		else
			cpu_di = gaplus_pkg::unmapped_data;  // open bus.
	end

endmodule

// ==== gaplus_main.sv ====
/*
  main-CPU bus glue top level.
  the CPU core and the ROM/RAM arrays sit outside; their bus
  signals come in as loose ports.
  write cycle = cpu_vma high with cpu_rw low.
*/

`timescale 1ns/1ps

module gaplus_main (
	input  logic        MCPU_CLK,
	input  logic        RESET,
	input  logic        vblk,

	// player inputs.
	input  logic [31:0] inp0,
	input  logic [31:0] inp1,
	input  logic [3:0]  inp2,

	// main CPU bus.
	input  logic [15:0] cpu_addr,
	input  logic        cpu_vma,
	input  logic        cpu_rw,
	input  logic [7:0]  cpu_do,
	output logic [7:0]  cpu_di,
	output logic        cpu_irq,

	// program ROM.
	output logic        rom_cs,
	output logic [14:0] rom_addr,
	input  logic [7:0]  rom_data,

	// work RAM and sound RAM windows.
	output logic        ram_we,
	input  logic [7:0]  ram_rd,
	output logic        snd_we,
	input  logic [7:0]  snd_rd,

	output logic        star_cs,
	output logic        sub_reset,
	output logic        kick_explode
);

	logic       io_cs;
	logic [7:0] io_rd;

	// ----------------------------------------------------------------------
	// decode, latches and read mux
	// ----------------------------------------------------------------------
	gaplus_main_decode decode0 (
		.MCPU_CLK  (MCPU_CLK),
		.RESET     (RESET),
		.vblk      (vblk),
		.cpu_addr  (cpu_addr),
		.cpu_vma   (cpu_vma),
		.cpu_rw    (cpu_rw),
		.rom_data  (rom_data),
		.ram_rd    (ram_rd),
		.snd_rd    (snd_rd),
		.io_rd     (io_rd),
		.rom_cs    (rom_cs),
		.rom_addr  (rom_addr),
		.ram_we    (ram_we),
		.snd_we    (snd_we),
		.star_cs   (star_cs),
		.io_cs     (io_cs),
		.sub_reset (sub_reset),
		.cpu_irq   (cpu_irq),
		.cpu_di    (cpu_di)
	);

	// ----------------------------------------------------------------------
	// custom I/O chips
	// ----------------------------------------------------------------------
	gaplus_io io0 (
		.MCPU_CLK     (MCPU_CLK),
		.RESET        (RESET),
		.vblk         (vblk),
		.cpu_addr     (cpu_addr),
		.cpu_rw       (cpu_rw),
		.cpu_do       (cpu_do),
		.io_cs        (io_cs),
		.inp0         (inp0),
		.inp1         (inp1),
		.inp2         (inp2),
		.io_rd        (io_rd),
		.kick_explode (kick_explode)
	);

endmodule

// ==== tb_gaplus_main.sv ====
/*
  trace-driven testbench for the main-CPU bus glue.
  one trace step takes one clock: inputs go out on the rising edge,
  outputs are checked at the falling edge of the same cycle.
  cpu_di is checked on R steps only, rom_addr on R and W steps.
  the trace is opened relative to the directory the simulator runs in.
*/

`timescale 1ns/1ps

module tb_gaplus_main;

	logic        MCPU_CLK;
	logic        RESET;
	logic        vblk;
	logic [31:0] inp0;
	logic [31:0] inp1;
	logic [3:0]  inp2;
	logic [15:0] cpu_addr;
	logic        cpu_vma;
	logic        cpu_rw;
	logic [7:0]  cpu_do;
	logic [7:0]  cpu_di;
	logic        cpu_irq;
	logic        rom_cs;
	logic [14:0] rom_addr;
	logic [7:0]  rom_data;
	logic        ram_we;
	logic [7:0]  ram_rd;
	logic        snd_we;
	logic [7:0]  snd_rd;
	logic        star_cs;
	logic        sub_reset;
	logic        kick_explode;

	int fd;
	int code;
	int line_count;
	int cycle_cnt   = 0;
	int cycle_limit = 0;

	// fields of one trace step.
	logic [7:0]  op;
	logic [31:0] f_addr;
	logic [31:0] f_data;
	logic [31:0] f_word;
	logic [31:0] e_di;
	logic [31:0] e_strb;
	logic [31:0] e_irq;
	logic [31:0] e_srst;
	logic [31:0] e_kick;
	logic [8*256-1:0] text_line;

	gaplus_main dut0 (
		.MCPU_CLK     (MCPU_CLK),
		.RESET        (RESET),
		.vblk         (vblk),
		.inp0         (inp0),
		.inp1         (inp1),
		.inp2         (inp2),
		.cpu_addr     (cpu_addr),
		.cpu_vma      (cpu_vma),
		.cpu_rw       (cpu_rw),
		.cpu_do       (cpu_do),
		.cpu_di       (cpu_di),
		.cpu_irq      (cpu_irq),
		.rom_cs       (rom_cs),
		.rom_addr     (rom_addr),
		.rom_data     (rom_data),
		.ram_we       (ram_we),
		.ram_rd       (ram_rd),
		.snd_we       (snd_we),
		.snd_rd       (snd_rd),
		.star_cs      (star_cs),
		.sub_reset    (sub_reset),
		.kick_explode (kick_explode)
	);

	// ----------------------------------------------------------------------
	// clock and timeout
	// ----------------------------------------------------------------------
	initial begin
		MCPU_CLK = 1'b0;
		forever #10 MCPU_CLK = ~MCPU_CLK;  // 20 ns period.
	end

	always @(posedge MCPU_CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout: trace not finished after %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] time %0t: %s is %0h, expected %0h", $time, name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "%s", why);
	endtask

	task bus_idle;
		cpu_vma  <= 1'b0;
		cpu_rw   <= 1'b1;
		cpu_addr <= 16'h0000;
		cpu_do   <= 8'h00;
	endtask

	// one trace step, one clock.
	task run_step;
		code = $fscanf(fd, "%h %h %h %h %h %h %h %h", f_addr, f_data, f_word,
			e_di, e_strb, e_irq, e_srst, e_kick);
		if (code != 8)
			abort_run("malformed line in trace file");
		@(posedge MCPU_CLK);
		case (op)
			"W": begin
				cpu_vma  <= 1'b1;
				cpu_rw   <= 1'b0;
				cpu_addr <= f_addr[15:0];
				cpu_do   <= f_data[7:0];
			end
			"R": begin
				cpu_vma  <= 1'b1;
				cpu_rw   <= 1'b1;
				cpu_addr <= f_addr[15:0];
				cpu_do   <= 8'h00;
			end
			"V": begin
				bus_idle();
				vblk <= f_data[0];
			end
			"I": begin
				bus_idle();
				case (f_addr[1:0])
					2'd0: inp0 <= f_word;
					2'd1: inp1 <= f_word;
					2'd2: inp2 <= f_word[3:0];
					default: begin  // fixed memory read bytes.
						rom_data <= f_word[7:0];
						ram_rd   <= f_word[15:8];
						snd_rd   <= f_word[23:16];
					end
				endcase
			end
			default: abort_run("unknown operation letter in trace file");
		endcase
		@(negedge MCPU_CLK);
		if (op == "R")
			check_value("cpu_di", 32'(cpu_di), e_di);
		if (op == "R" || op == "W")
			check_value("rom_addr", 32'(rom_addr), 32'(f_addr[14:0]));
		check_value("{star_cs,snd_we,ram_we,rom_cs}",
			32'({star_cs, snd_we, ram_we, rom_cs}), e_strb);
		check_value("cpu_irq", 32'(cpu_irq), e_irq);
		check_value("sub_reset", 32'(sub_reset), e_srst);
		check_value("kick_explode", 32'(kick_explode), e_kick);
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		RESET     = 1'b1;
		vblk      = 1'b0;
		inp0      = 32'h0;
		inp1      = 32'h0;
		inp2      = 4'h0;
		cpu_addr  = 16'h0000;
		cpu_vma   = 1'b0;
		cpu_rw    = 1'b1;
		cpu_do    = 8'h00;
		rom_data  = 8'h00;
		ram_rd    = 8'h00;
		snd_rd    = 8'h00;

		// size the cycle limit from the trace length.
		fd = $fopen("gaplus_main_trace.txt", "r");
		if (fd == 0)
			abort_run("trace file gaplus_main_trace.txt could not be opened");
		line_count = 0;
		while ($fgets(text_line, fd) != 0)
			line_count++;
		$fclose(fd);
		cycle_limit = line_count * 4 + 100;

		repeat (8) @(posedge MCPU_CLK);
		RESET <= 1'b0;

		fd = $fopen("gaplus_main_trace.txt", "r");
		if (fd == 0)
			abort_run("trace file gaplus_main_trace.txt could not be reopened");
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %c", op);
			if (code == 1) begin
				if (op == "#")
					code = $fgets(text_line, fd);  // comment line.
				else
					run_step();
			end
		end
		$fclose(fd);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== gaplus_main_trace.txt ====
# op addr data word | expected: cpu_di strobes{star,snd,ram,rom} cpu_irq sub_reset kick (hex)
# W write, R read, V vblk=data[0], I addr 0/1/2 = inp0/inp1/inp2, 3 = rom/ram/snd bytes [7:0]/[15:8]/[23:16]
I 0003 00 00A55AC3 00 0 0 1 0
# decode and read priority
R 8000 00 00000000 C3 1 0 1 0
R 0000 00 00000000 5A 0 0 1 0
R 6000 00 00000000 A5 0 0 1 0
R 6800 00 00000000 00 0 0 1 0
R 2000 00 00000000 FF 0 0 1 0
R A000 00 00000000 C3 1 0 1 0
W 0000 12 00000000 00 2 0 1 0
W 6000 34 00000000 00 4 0 1 0
W A000 00 00000000 00 9 0 1 0
R 4000 00 00000000 FF 0 0 1 0
# control latches
W 8000 00 00000000 00 1 0 1 0
R 2000 00 00000000 FF 0 0 0 0
W 8800 00 00000000 00 1 0 0 0
R 2000 00 00000000 FF 0 0 1 0
# interrupt gating
V 0000 01 00000000 00 0 0 1 0
W 7000 00 00000000 00 0 0 1 0
R 2000 00 00000000 FF 0 1 1 0
W 7800 00 00000000 00 0 1 1 0
R 2000 00 00000000 FF 0 0 1 0
V 0000 00 00000000 00 0 0 1 0
# I/O register file
W 6813 A7 00000000 00 0 0 1 0
R 6813 00 00000000 07 0 0 1 0
R 6830 00 00000000 00 0 0 1 0
W 6800 05 00000000 00 0 0 1 0
W 6801 0C 00000000 00 0 0 1 0
W 6808 08 00000000 00 0 0 1 0
R 6800 00 00000000 0A 0 0 1 0
R 6801 00 00000000 03 0 0 1 0
R 6808 00 00000000 08 0 0 1 0
W 6808 00 00000000 00 0 0 1 0
R 6800 00 00000000 05 0 0 1 0
# vblank capture
I 0000 00 87654321 00 0 0 1 0
I 0001 00 FEDCBA98 00 0 0 1 0
I 0002 00 0000000B 00 0 0 1 0
W 6818 01 00000000 00 0 0 1 0
W 6828 01 00000000 00 0 0 1 0
V 0000 01 00000000 00 0 0 1 0
R 6810 00 00000000 08 0 0 1 0
R 6817 00 00000000 0F 0 0 1 0
R 6812 00 00000000 0A 0 0 1 0
R 6813 00 00000000 0B 0 0 1 0
R 6820 00 00000000 0B 0 0 1 0
R 6818 00 00000000 01 0 0 1 0
R 6800 00 00000000 05 0 0 1 0
R 6801 00 00000000 0C 0 0 1 0
V 0000 00 00000000 00 0 0 1 0
W 6808 01 00000000 00 0 0 1 0
V 0000 01 00000000 00 0 0 1 0
R 6800 00 00000000 01 0 0 1 0
R 6803 00 00000000 04 0 0 1 0
R 6807 00 00000000 08 0 0 1 0
R 6808 00 00000000 01 0 0 1 0
V 0000 00 00000000 00 0 0 1 0
# explosion trigger
W 6829 03 00000000 00 0 0 1 0
R 2000 00 00000000 FF 0 0 1 1
R 2000 00 00000000 FF 0 0 1 0
W 6829 00 00000000 00 0 0 1 0
R 2000 00 00000000 FF 0 0 1 0
R 6829 00 00000000 00 0 0 1 0

// ==== sim.f ====
gaplus_pkg.sv
gaplus_io.sv
gaplus_main_decode.sv
gaplus_main.sv
tb_gaplus_main.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the trace-driven testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f sim.f \
	--top-module tb_gaplus_main -o tb_gaplus_main

output=$(./obj_dir/tb_gaplus_main 2>&1) || true
echo "$output"

if grep -q "^Simulation finished: PASS$" <<< "$output"; then
	exit 0
else
	exit 1
fi
